// File: build.f
src/dcache_pkg.sv
src/dcache_lookup.sv
src/dcache_store_buffer.sv
src/dcache_line_fsm.sv
src/dcache_array.sv
src/dcache_top.sv
sim/tb_dcache.sv

// File: run.sh
#!/bin/sh
# compile and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_dcache \
  -f build.f \
  -o tb_dcache

# exit status of the simulation is the test result
./obj_dir/tb_dcache

// File: sim/dcache_stimulus.txt
// columns: kind addr data be expect, all hex, image records first, end record last
// kind 0 image word, 1 load, 2 store, 3 clean (expect is write count), 4 memory check, f end
0 040 11111111 0 0
0 044 22222222 0 0
0 080 33333333 0 0
0 084 44444444 0 0
0 108 77777777 0 0
0 10c 88888888 0 0
1 040 00000000 0 11111111
1 040 00000000 0 11111111
1 044 00000000 0 22222222
2 044 aabbccdd 3 0
1 044 00000000 0 2222ccdd
1 080 00000000 0 33333333
2 10c 12345678 c 0
1 10c 00000000 0 12348888
2 080 0000ff00 2 0
3 000 00000000 0 2
3 000 00000000 0 0
4 040 00000000 0 11111111
4 044 00000000 0 2222ccdd
4 080 00000000 0 3333ff33
4 084 00000000 0 44444444
4 10c 00000000 0 12348888
f 000 00000000 0 0

// File: sim/tb_dcache.sv
module tb_dcache;

  timeunit 1ns;
  timeprecision 1ps;

  logic                  clk_i;
  logic                  rst_ni      = 1'b0;
  logic                  core_req_i  = 1'b0;
  dcache_pkg::core_req_t core_cmd_i  = '0;
  logic                  core_ack_o;
  dcache_pkg::word_t     core_rdata_o;
  logic                  clean_req_i = 1'b0;
  logic                  clean_ack_o;
  logic                  mem_req_o;
  dcache_pkg::mem_cmd_t  mem_cmd_o;
  logic                  mem_ack_i   = 1'b0;
  dcache_pkg::line_t     mem_rline_i = '0;

  // five hex words per record: kind, addr, data, be, expect
  logic [31:0]       stim  [320];
  dcache_pkg::word_t mem_q [1024];
  dcache_pkg::word_t ref_q [1024];
  logic [31:0]       rng_q       = 32'h7485_38ac;
  logic [1:0]        wait_q      = 2'd0;
  int unsigned       mem_writes  = 0;
  int unsigned       cycles      = 0;
  int unsigned       cycle_limit = 0;

  dcache_top u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .core_req_i(core_req_i), .core_cmd_i(core_cmd_i),
    .core_ack_o(core_ack_o), .core_rdata_o(core_rdata_o),
    .clean_req_i(clean_req_i), .clean_ack_o(clean_ack_o),
    .mem_req_o(mem_req_o), .mem_cmd_o(mem_cmd_o),
    .mem_ack_i(mem_ack_i), .mem_rline_i(mem_rline_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // bytes with their enable set come from the new word
  function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                    input dcache_pkg::word_t new_w,
                                                    input dcache_pkg::be_t be);
    dcache_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////
  task automatic serve_memory();
    logic [9:0] w;
    w = {mem_cmd_o.tag, mem_cmd_o.idx, 1'b0};
    if (mem_cmd_o.we) begin
      // a written-back line holds every store made to it so far
      check_value($sformatf("writeback %03h", {w, 2'b00}), ref_q[w],
                  mem_cmd_o.wline[31:0]);
      check_value($sformatf("writeback %03h", {w + 10'd1, 2'b00}), ref_q[w + 10'd1],
                  mem_cmd_o.wline[63:32]);
      mem_q[w]         = mem_cmd_o.wline[31:0];
      mem_q[w + 10'd1] = mem_cmd_o.wline[63:32];
      mem_writes       = mem_writes + 1;
    end else begin
      mem_rline_i <= {mem_q[w + 10'd1], mem_q[w]};
    end
  endtask

  always @(posedge clk_i) begin
    if (mem_ack_i) begin
      if (!mem_req_o) begin
        mem_ack_i <= 1'b0;
      end
    end else if (mem_req_o) begin
      if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else begin
        serve_memory();
        mem_ack_i <= 1'b1;
        rng_q     <= xorshift32(rng_q);
        wait_q    <= rng_q[1:0];
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Test failures found");
      $fatal(1, "timeout: the DUT did not respond within %0d cycles", cycle_limit);
    end
  end

  ////////////////////////////////////////
  // core and clean port drivers
  ////////////////////////////////////////
  task automatic access_word(input logic we, input dcache_pkg::addr_t addr,
                             input dcache_pkg::word_t data, input dcache_pkg::be_t be,
                             output dcache_pkg::word_t rdata);
    @(posedge clk_i);
    core_req_i <= 1'b1;
    core_cmd_i <= '{we: we, addr: addr, wdata: data, be: be};
    do @(posedge clk_i); while (!core_ack_o);
    rdata = core_rdata_o;
    core_req_i <= 1'b0;
    do @(posedge clk_i); while (core_ack_o);
  endtask

  task automatic run_clean();
    @(posedge clk_i);
    clean_req_i <= 1'b1;
    do @(posedge clk_i); while (!clean_ack_o);
    clean_req_i <= 1'b0;
    do @(posedge clk_i); while (clean_ack_o);
  endtask

  initial begin
    int                rec;
    logic [31:0]       kind;
    dcache_pkg::addr_t addr;
    dcache_pkg::word_t data;
    dcache_pkg::be_t   be;
    logic [31:0]       expect_v;
    dcache_pkg::word_t rdata;
    int unsigned       writes_before;

    // untouched words get an address-dependent pattern
    for (int i = 0; i < 1024; i++) begin
      mem_q[i] = 32'hc0de_0000 ^ (i * 32'h0001_0001);
    end
    $readmemh("sim/dcache_stimulus.txt", stim);
    rec = 0;
    while (rec < 64 && stim[rec*5] == 32'h0) begin
      mem_q[stim[rec*5+1][11:2]] = stim[rec*5+2];
      rec++;
    end
    for (int i = 0; i < 1024; i++) begin
      ref_q[i] = mem_q[i];
    end
    while (rec < 64 && stim[rec*5] !== 32'hf) begin
      rec++;
    end
    if (rec >= 64 || stim[rec*5] !== 32'hf) begin
      $display("Test failures found");
      $fatal(1, "stimulus file is missing or has no end record");
    end
    cycle_limit = 200 * rec;

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    for (int r = 0; r < rec; r++) begin
      kind     = stim[r*5];
      addr     = stim[r*5+1][11:0];
      data     = stim[r*5+2];
      be       = stim[r*5+3][3:0];
      expect_v = stim[r*5+4];
      case (kind)
        32'h0: begin
        end
        32'h1: begin
          access_word(1'b0, addr, data, be, rdata);
          check_value($sformatf("load %03h", addr), expect_v, rdata);
        end
        32'h2: begin
          ref_q[addr[11:2]] = merge_bytes(ref_q[addr[11:2]], data, be);
          access_word(1'b1, addr, data, be, rdata);
        end
        32'h3: begin
          writes_before = mem_writes;
          run_clean();
          check_value($sformatf("clean writes, record %0d", r), expect_v,
                      mem_writes - writes_before);
        end
        32'h4: begin
          check_value($sformatf("memory %03h", addr), expect_v, mem_q[addr[11:2]]);
        end
        default: begin
          $display("Test failures found");
          $fatal(1, "unknown operation kind %0h in record %0d", kind, r);
        end
      endcase
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: src/dcache_array.sv
module dcache_array (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  dcache_pkg::idx_t  rd_idx_i,
  input  dcache_pkg::idx_t  vic_idx_i,
  input  logic              lw_en_i,
  input  dcache_pkg::idx_t  lw_idx_i,
  input  dcache_pkg::tag_t  lw_tag_i,
  input  dcache_pkg::line_t lw_line_i,
  input  logic              lw_dirty_i,
  input  logic              sw_en_i,
  input  dcache_pkg::idx_t  sw_idx_i,
  input  logic              sw_offs_i,
  input  dcache_pkg::word_t sw_word_i,
  input  dcache_pkg::be_t   sw_be_i,
  output dcache_pkg::tag_t  rd_tag_o,
  output logic              rd_valid_o,
  output dcache_pkg::line_t rd_line_o,
  output dcache_pkg::tag_t  vic_tag_o,
  output logic              vic_valid_o,
  output logic              vic_dirty_o,
  output dcache_pkg::line_t vic_line_o
);

  dcache_pkg::tag_t            tag_mem  [dcache_pkg::SETS];
  dcache_pkg::line_t           data_mem [dcache_pkg::SETS];
  logic [dcache_pkg::SETS-1:0] valid_q;
  logic [dcache_pkg::SETS-1:0] dirty_q;
  dcache_pkg::idx_t            rd_idx_q;
  dcache_pkg::idx_t            vic_idx_q;

  // registered read index, so a write at the same edge is seen
  always_ff @(posedge clk_i) begin
    rd_idx_q  <= rd_idx_i;
    vic_idx_q <= vic_idx_i;
  end

  assign rd_tag_o    = tag_mem[rd_idx_q];
  assign rd_valid_o  = valid_q[rd_idx_q];
  assign rd_line_o   = data_mem[rd_idx_q];
  assign vic_tag_o   = tag_mem[vic_idx_q];
  assign vic_valid_o = valid_q[vic_idx_q];
  assign vic_dirty_o = dirty_q[vic_idx_q];
  assign vic_line_o  = data_mem[vic_idx_q];

  ////////////////////////////////////////
  // line and word writes
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (lw_en_i) begin
      tag_mem[lw_idx_i]  <= lw_tag_i;
      data_mem[lw_idx_i] <= lw_line_i;
    end
    if (sw_en_i) begin
      for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
        if (sw_be_i[b]) begin
          data_mem[sw_idx_i][sw_offs_i * dcache_pkg::WORD_W + b * 8 +: 8] <=
            sw_word_i[b * 8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (lw_en_i) begin
        valid_q[lw_idx_i] <= 1'b1;
        dirty_q[lw_idx_i] <= lw_dirty_i;
      end
      // store drain marks the line for write-back
      if (sw_en_i) begin
        dirty_q[sw_idx_i] <= 1'b1;
      end
    end
  end

  a_one_writer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lw_en_i && sw_en_i));

endmodule

// File: src/dcache_line_fsm.sv
module dcache_line_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 miss_i,
  input  dcache_pkg::lookup_t  miss_info_i,
  input  logic                 sb_full_i,
  input  logic                 clean_req_i,
  input  logic                 mem_ack_i,
  input  dcache_pkg::line_t    mem_rline_i,
  input  dcache_pkg::tag_t     vic_tag_i,
  input  logic                 vic_valid_i,
  input  logic                 vic_dirty_i,
  input  dcache_pkg::line_t    vic_line_i,
  output logic                 fill_done_o,
  output logic                 busy_o,
  output logic                 clean_ack_o,
  output logic                 mem_req_o,
  output dcache_pkg::mem_cmd_t mem_cmd_o,
  output dcache_pkg::idx_t     vic_idx_o,
  output logic                 lw_en_o,
  output dcache_pkg::idx_t     lw_idx_o,
  output dcache_pkg::tag_t     lw_tag_o,
  output dcache_pkg::line_t    lw_line_o,
  output logic                 lw_dirty_o
);

  dcache_pkg::line_state_e state_q;
  dcache_pkg::idx_t        scan_idx_q;
  logic                    scan_rdy_q;
  logic                    rec_cnt_q;
  logic                    filling;
  logic                    scanning;
  logic                    mem_done;
  logic                    vic_dirty;
  logic                    scan_step;
  logic                    scan_last;

  assign filling   = (state_q == dcache_pkg::FILL);
  assign scanning  = (state_q == dcache_pkg::CLEAN_SCAN);
  assign mem_done  = mem_req_o & mem_ack_i;
  assign vic_dirty = vic_valid_i & vic_dirty_i;
  assign busy_o    = (state_q != dcache_pkg::IDLE);

  // victim read follows the scan pointer during clean, else the miss
  assign vic_idx_o = scanning ? scan_idx_q : miss_info_i.idx;

  // next set once the current one is clean or written back
  assign scan_step = mem_done | (scan_rdy_q & ~mem_req_o & ~vic_dirty);
  assign scan_last = (scan_idx_q == dcache_pkg::idx_t'(dcache_pkg::SETS - 1));

  ////////////////////////////////////////
  // array line write
  ////////////////////////////////////////
  assign lw_en_o    = mem_done & (filling | scanning);
  assign lw_idx_o   = vic_idx_o;
  assign lw_tag_o   = filling ? miss_info_i.tag : vic_tag_i;
  assign lw_line_o  = filling ? mem_rline_i : vic_line_i;
  // a store miss installs dirty, clean writes clear it
  assign lw_dirty_o = filling & miss_info_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= dcache_pkg::IDLE;
      mem_req_o   <= 1'b0;
      clean_ack_o <= 1'b0;
      fill_done_o <= 1'b0;
      scan_idx_q  <= '0;
      scan_rdy_q  <= 1'b0;
      rec_cnt_q   <= 1'b0;
    end else begin
      fill_done_o <= 1'b0;
      unique case (state_q)
        dcache_pkg::IDLE: begin
          if (clean_ack_o && !clean_req_i) begin
            clean_ack_o <= 1'b0;
          end
          // miss is still high in the cycle of fill_done
          if (miss_i && !fill_done_o && !sb_full_i) begin
            state_q <= dcache_pkg::WRITEBACK;
          end else if (clean_req_i && !clean_ack_o && !sb_full_i) begin
            state_q    <= dcache_pkg::CLEAN_SCAN;
            scan_idx_q <= '0;
            scan_rdy_q <= 1'b0;
          end
        end
        dcache_pkg::WRITEBACK: begin
          if (mem_done) begin
            mem_req_o <= 1'b0;
            state_q   <= dcache_pkg::FILL;
          end else if (!mem_req_o) begin
            if (!vic_dirty) begin
              state_q <= dcache_pkg::FILL;
            end else if (!mem_ack_i) begin
              mem_req_o <= 1'b1;
            end
          end
        end
        dcache_pkg::FILL: begin
          if (mem_done) begin
            mem_req_o <= 1'b0;
            rec_cnt_q <= 1'b0;
            state_q   <= dcache_pkg::RECOVER;
          end else if (!mem_req_o && !mem_ack_i) begin
            mem_req_o <= 1'b1;
          end
        end
        // two cycles for the array read to see the new line
        dcache_pkg::RECOVER: begin
          rec_cnt_q <= 1'b1;
          if (rec_cnt_q) begin
            fill_done_o <= 1'b1;
            state_q     <= dcache_pkg::IDLE;
          end
        end
        dcache_pkg::CLEAN_SCAN: begin
          if (mem_done) begin
            mem_req_o <= 1'b0;
          end else if (!scan_rdy_q) begin
            scan_rdy_q <= 1'b1;
          end else if (!mem_req_o && vic_dirty && !mem_ack_i) begin
            mem_req_o <= 1'b1;
          end
          if (scan_step) begin
            scan_rdy_q <= 1'b0;
            scan_idx_q <= scan_idx_q + 1'b1;
            // a store pushed meanwhile gets drained, then scan again
            if (scan_last) begin
              clean_ack_o <= !sb_full_i;
              state_q     <= dcache_pkg::IDLE;
            end
          end
        end
        default: state_q <= dcache_pkg::IDLE;
      endcase
    end
  end

  // command is captured while req is low and held until ack
  always_ff @(posedge clk_i) begin
    if (!mem_req_o) begin
      mem_cmd_o.we    <= !filling;
      mem_cmd_o.tag   <= filling ? miss_info_i.tag : vic_tag_i;
      mem_cmd_o.idx   <= vic_idx_o;
      mem_cmd_o.wline <= vic_line_i;
    end
  end

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_cmd_o));

endmodule

// File: src/dcache_lookup.sv
module dcache_lookup (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  core_req_i,
  input  dcache_pkg::core_req_t core_cmd_i,
  input  dcache_pkg::tag_t      rd_tag_i,
  input  logic                  rd_valid_i,
  input  dcache_pkg::line_t     rd_line_i,
  input  logic                  fill_done_i,
  input  logic                  sb_full_i,
  input  dcache_pkg::line_t     sb_bypass_line_i,
  output logic                  core_ack_o,
  output dcache_pkg::word_t     core_rdata_o,
  output dcache_pkg::idx_t      rd_idx_o,
  output logic                  miss_o,
  output dcache_pkg::lookup_t   miss_info_o,
  output logic                  sb_push_o,
  output dcache_pkg::word_t     sb_word_o,
  output dcache_pkg::be_t       sb_be_o,
  output dcache_pkg::idx_t      sb_idx_o,
  output logic                  sb_offs_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_MISS,
    S_ACK
  } state_e;

  state_e                state_q;
  dcache_pkg::core_req_t req_q;
  dcache_pkg::tag_t      req_tag;
  dcache_pkg::idx_t      req_idx;
  logic                  req_offs;
  dcache_pkg::line_t     load_line;
  logic                  hit;

  ////////////////////////////////////////
  // address split
  ////////////////////////////////////////
  assign req_tag  = req_q.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
  assign req_idx  = req_q.addr[dcache_pkg::OFFS_W +: dcache_pkg::IDX_W];
  // upper offset bit picks the word of the line
  assign req_offs = req_q.addr[dcache_pkg::OFFS_W-1];

  // a new request indexes the array straight from the port
  always_comb begin
    rd_idx_o = req_idx;
    if (state_q == S_IDLE) begin
      rd_idx_o = core_cmd_i.addr[dcache_pkg::OFFS_W +: dcache_pkg::IDX_W];
    end
  end

  assign hit = rd_valid_i && (rd_tag_i == req_tag);

  // merged line only differs while a store is pending
  assign load_line = sb_full_i ? sb_bypass_line_i : rd_line_i;

  assign miss_info_o = '{tag: req_tag, idx: req_idx, we: req_q.we};

  // store hits go to the buffer, one push per access
  assign sb_push_o = (state_q == S_READ) && hit && req_q.we && !sb_full_i;
  assign sb_word_o = req_q.wdata;
  assign sb_be_o   = req_q.be;
  assign sb_idx_o  = req_idx;
  assign sb_offs_o = req_offs;

  ////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= S_IDLE;
      core_ack_o <= 1'b0;
      miss_o     <= 1'b0;
    end else begin
      unique case (state_q)
        S_IDLE: begin
          if (core_req_i) begin
            state_q <= S_READ;
          end
        end
        S_READ: begin
          if (!hit) begin
            miss_o  <= 1'b1;
            state_q <= S_MISS;
          end else if (!req_q.we || !sb_full_i) begin
            core_ack_o <= 1'b1;
            state_q    <= S_ACK;
          end
        end
        // line is in place after fill_done, look again
        S_MISS: begin
          if (fill_done_i) begin
            miss_o  <= 1'b0;
            state_q <= S_READ;
          end
        end
        S_ACK: begin
          if (!core_req_i) begin
            core_ack_o <= 1'b0;
            state_q    <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && core_req_i) begin
      req_q <= core_cmd_i;
    end
    if (state_q == S_READ && hit && !req_q.we) begin
      core_rdata_o <= load_line[req_offs * dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    end
  end

  a_miss_no_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(miss_o && core_ack_o));

endmodule

// File: src/dcache_pkg.sv
package dcache_pkg;

  ////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////
  localparam int ADDR_W     = 12;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 2;
  localparam int SETS       = 8;

  // byte offset inside a line, then set index, the rest is tag
  localparam int OFFS_W = $clog2(LINE_WORDS * WORD_W / 8);
  localparam int IDX_W  = $clog2(SETS);
  localparam int TAG_W  = ADDR_W - IDX_W - OFFS_W;

  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [WORD_W/8-1:0]          be_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [IDX_W-1:0]             idx_t;
  typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

  ////////////////////////////////////////
  // port and internal bundles
  ////////////////////////////////////////
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
    be_t   be;
  } core_req_t;

  // line address is tag plus index
  typedef struct packed {
    logic  we;
    tag_t  tag;
    idx_t  idx;
    line_t wline;
  } mem_cmd_t;

  // pending miss, held by lookup until fill_done
  typedef struct packed {
    tag_t tag;
    idx_t idx;
    logic we;
  } lookup_t;

  typedef enum logic [2:0] {
    IDLE,
    CLEAN_SCAN,
    WRITEBACK,
    FILL,
    RECOVER
  } line_state_e;

endpackage

// File: src/dcache_store_buffer.sv
module dcache_store_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  dcache_pkg::word_t word_i,
  input  dcache_pkg::be_t   be_i,
  input  dcache_pkg::idx_t  idx_i,
  input  logic              offs_i,
  input  logic              fsm_busy_i,
  input  dcache_pkg::idx_t  rd_idx_i,
  input  dcache_pkg::line_t rd_line_i,
  output logic              full_o,
  output dcache_pkg::line_t bypass_line_o,
  output logic              wr_en_o,
  output dcache_pkg::idx_t  wr_idx_o,
  output logic              wr_offs_o,
  output dcache_pkg::word_t wr_word_o,
  output dcache_pkg::be_t   wr_be_o
);

  logic              full_q;
  dcache_pkg::idx_t  idx_q;
  logic              offs_q;
  dcache_pkg::word_t word_q;
  dcache_pkg::be_t   be_q;

  assign full_o = full_q;

  // drain only while the line FSM leaves the array alone
  assign wr_en_o   = full_q & ~fsm_busy_i;
  assign wr_idx_o  = idx_q;
  assign wr_offs_o = offs_q;
  assign wr_word_o = word_q;
  assign wr_be_o   = be_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (push_i) begin
      full_q <= 1'b1;
    end else if (wr_en_o) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      idx_q  <= idx_i;
      offs_q <= offs_i;
      word_q <= word_i;
      be_q   <= be_i;
    end
  end

  ////////////////////////////////////////
  // byte-wise read bypass
  ////////////////////////////////////////
  always_comb begin
    bypass_line_o = rd_line_i;
    if (full_q && (idx_q == rd_idx_i)) begin
      for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
        if (be_q[b]) begin
          bypass_line_o[offs_q * dcache_pkg::WORD_W + b * 8 +: 8] = word_q[b * 8 +: 8];
        end
      end
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full_o));

endmodule

// File: src/dcache_top.sv
module dcache_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  core_req_i,
  input  dcache_pkg::core_req_t core_cmd_i,
  output logic                  core_ack_o,
  output dcache_pkg::word_t     core_rdata_o,
  input  logic                  clean_req_i,
  output logic                  clean_ack_o,
  output logic                  mem_req_o,
  output dcache_pkg::mem_cmd_t  mem_cmd_o,
  input  logic                  mem_ack_i,
  input  dcache_pkg::line_t     mem_rline_i
);

  // lookup side
  dcache_pkg::idx_t    rd_idx;
  dcache_pkg::tag_t    rd_tag;
  logic                rd_valid;
  dcache_pkg::line_t   rd_line;
  dcache_pkg::line_t   bypass_line;
  logic                miss;
  dcache_pkg::lookup_t miss_info;
  logic                fill_done;
  logic                busy;

  // store buffer
  logic                sb_full;
  logic                sb_push;
  dcache_pkg::word_t   sb_word;
  dcache_pkg::be_t     sb_be;
  dcache_pkg::idx_t    sb_idx;
  logic                sb_offs;
  logic                sw_en;
  dcache_pkg::idx_t    sw_idx;
  logic                sw_offs;
  dcache_pkg::word_t   sw_word;
  dcache_pkg::be_t     sw_be;

  // victim read and line write
  dcache_pkg::idx_t    vic_idx;
  dcache_pkg::tag_t    vic_tag;
  logic                vic_valid;
  logic                vic_dirty;
  dcache_pkg::line_t   vic_line;
  logic                lw_en;
  dcache_pkg::idx_t    lw_idx;
  dcache_pkg::tag_t    lw_tag;
  dcache_pkg::line_t   lw_line;
  logic                lw_dirty;

  dcache_lookup u_lookup (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .core_req_i(core_req_i), .core_cmd_i(core_cmd_i),
    .rd_tag_i(rd_tag), .rd_valid_i(rd_valid), .rd_line_i(rd_line),
    .fill_done_i(fill_done), .sb_full_i(sb_full), .sb_bypass_line_i(bypass_line),
    .core_ack_o(core_ack_o), .core_rdata_o(core_rdata_o), .rd_idx_o(rd_idx),
    .miss_o(miss), .miss_info_o(miss_info),
    .sb_push_o(sb_push), .sb_word_o(sb_word), .sb_be_o(sb_be),
    .sb_idx_o(sb_idx), .sb_offs_o(sb_offs)
  );

  // a store miss lands here after the fill, when the retry hits
  dcache_store_buffer u_store_buffer (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .push_i(sb_push), .word_i(sb_word), .be_i(sb_be), .idx_i(sb_idx), .offs_i(sb_offs),
    .fsm_busy_i(busy), .rd_idx_i(rd_idx), .rd_line_i(rd_line),
    .full_o(sb_full), .bypass_line_o(bypass_line),
    .wr_en_o(sw_en), .wr_idx_o(sw_idx), .wr_offs_o(sw_offs),
    .wr_word_o(sw_word), .wr_be_o(sw_be)
  );

  dcache_line_fsm u_line_fsm (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .miss_i(miss), .miss_info_i(miss_info), .sb_full_i(sb_full),
    .clean_req_i(clean_req_i), .mem_ack_i(mem_ack_i), .mem_rline_i(mem_rline_i),
    .vic_tag_i(vic_tag), .vic_valid_i(vic_valid), .vic_dirty_i(vic_dirty),
    .vic_line_i(vic_line),
    .fill_done_o(fill_done), .busy_o(busy), .clean_ack_o(clean_ack_o),
    .mem_req_o(mem_req_o), .mem_cmd_o(mem_cmd_o), .vic_idx_o(vic_idx),
    .lw_en_o(lw_en), .lw_idx_o(lw_idx), .lw_tag_o(lw_tag),
    .lw_line_o(lw_line), .lw_dirty_o(lw_dirty)
  );

  dcache_array u_array (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .rd_idx_i(rd_idx), .vic_idx_i(vic_idx),
    .lw_en_i(lw_en), .lw_idx_i(lw_idx), .lw_tag_i(lw_tag),
    .lw_line_i(lw_line), .lw_dirty_i(lw_dirty),
    .sw_en_i(sw_en), .sw_idx_i(sw_idx), .sw_offs_i(sw_offs),
    .sw_word_i(sw_word), .sw_be_i(sw_be),
    .rd_tag_o(rd_tag), .rd_valid_o(rd_valid), .rd_line_o(rd_line),
    .vic_tag_o(vic_tag), .vic_valid_o(vic_valid), .vic_dirty_o(vic_dirty),
    .vic_line_o(vic_line)
  );

endmodule
